/* ft601_wr_path.f */
+incdir+verilog
verilog/ft601_pkg.sv
verilog/async_word_fifo.sv
verilog/xfer_size_handshake.sv
verilog/ft601_mcfifo_wr_buf.sv
verilog/ft601_burst_reader.sv
verilog/ft601_wr_path_top.sv
tests/ft601_wr_path_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the FT601 write path testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module ft601_wr_path_tb \
    -f ft601_wr_path.f \
    --Mdir obj_dir \
    -o ft601_wr_path_sim

# The simulator exit status is not trusted, the log decides
./obj_dir/ft601_wr_path_sim 2>&1 | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi

echo "Simulation finished without a reported failure"

/* tests/ft601_wr_path_tb.sv */
/*
  Testbench for the FT601 write path with 1024 byte packets
  Words are written one per wr_clk on the falling edge and must respect full
  A push is issued only once earlier packets have drained, so boundaries are fixed
  The host pause in the load test is made by stopping rd_clk
*/
`timescale 1ns/1ps
`include "ft601_params.svh"

module ft601_wr_path_tb
    import ft601_pkg::*;
;

    localparam int MAX_PACKET_SIZE = 1024;
    localparam int WORD_BYTES      = `FT601_BYTES_PER_WORD;
    localparam int PKT_WORDS       = MAX_PACKET_SIZE / WORD_BYTES;
    localparam int CAP_WORDS       = `FT601_CAPACITY / WORD_BYTES;
    localparam int WR_PERIOD       = 40;
    localparam int RD_PERIOD       = 30;
    localparam int QUIET_CYCLES    = 100;
    localparam int LOAD_PACKETS    = 4;
    // Most words any run can write, the load test stops at capacity at the latest
    localparam int MAX_WORDS   = PKT_WORDS + 10 + LOAD_PACKETS * PKT_WORDS + CAP_WORDS;
    localparam int MAX_PACKETS = MAX_WORDS / PKT_WORDS + 2;
    // Writer pace dominates, each packet adds about a microsecond of handshake
    localparam longint DRAIN_NS = longint'(MAX_WORDS) * WR_PERIOD + MAX_PACKETS * 1000
                                + 4 * QUIET_CYCLES * WR_PERIOD;
    localparam longint TIMEOUT_NS = 4 * DRAIN_NS;

    logic        wr_clk = 1'b0;
    logic        rd_clk = 1'b0;
    logic        rd_run = 1'b1; // Low while the host side pauses
    logic        wr_reset;
    logic        rd_reset;
    ft601_word_t in_word;
    logic        in_valid;
    logic        push;
    logic        full;
    logic        almost_full;
    logic        has_packet_space;
    ft601_out_t  out_word;
    logic        out_valid;

    ft601_out_t  exp_q [$];         // Expected words in output order
    ft601_out_t  exp_item;
    logic        in_packet = 1'b0;  // A packet has started and its last word is still due
    int          model_held = 0;    // Bytes of the packet being built by the reference
    logic [31:0] rng_state = 32'hc627d81b;

    ft601_wr_path_top #(
        .MAX_PACKET_SIZE (MAX_PACKET_SIZE)
    ) u_dut (
        .wr_clk           (wr_clk),
        .wr_reset         (wr_reset),
        .in_word          (in_word),
        .in_valid         (in_valid),
        .push             (push),
        .full             (full),
        .almost_full      (almost_full),
        .has_packet_space (has_packet_space),
        .rd_clk           (rd_clk),
        .rd_reset         (rd_reset),
        .out_word         (out_word),
        .out_valid        (out_valid)
    );

    always #(WR_PERIOD / 2) wr_clk = ~wr_clk;

    always begin
        #(RD_PERIOD / 2);
        rd_clk = rd_run ? ~rd_clk : 1'b0; // Parked low while stopped
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Packet closes on the word that brings it to MAX_PACKET_SIZE bytes
    function automatic ft601_out_t ref_packetize(input ft601_word_t w, input int held_before);
        ft601_out_t o;
        o.word = w;
        o.last = (held_before + WORD_BYTES >= MAX_PACKET_SIZE);
        return o;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped at the first error, time %0t", $time);
    endtask

    task automatic check_word(input string name, input ft601_word_t got, input ft601_word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_last(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED %s: got %h expected %h", name, got, exp));
        end
    endtask

    // Called on a falling wr_clk edge, returns on the next one
    task automatic write_word(input bit random_be);
        ft601_word_t w;
        ft601_out_t  o;
        logic [31:0] r;
        w.data = next_rand();
        r      = next_rand();
        w.be   = random_be ? r[3:0] : 4'hf;
        o      = ref_packetize(w, model_held);
        exp_q.push_back(o);
        model_held = o.last ? 0 : model_held + WORD_BYTES;
        in_word  = w;
        in_valid = 1'b1;
        @(negedge wr_clk);
        in_valid = 1'b0;
    endtask

    // The held tail becomes a short packet
    task automatic flush();
        ft601_out_t tail;
        if (model_held != 0) begin
            tail = exp_q.pop_back();
            tail.last = 1'b1;
            exp_q.push_back(tail);
            model_held = 0;
        end
        push = 1'b1;
        @(negedge wr_clk);
        push = 1'b0;
    endtask

    task automatic wait_drained(input int words_left);
        while (exp_q.size() > words_left) begin
            @(negedge wr_clk);
        end
    endtask

    // Sampled mid-cycle where the registered outputs are settled
    always @(negedge rd_clk) begin
        if (!rd_reset) begin
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    abort_run("A word came out when no word was expected");
                end
                exp_item = exp_q.pop_front();
                check_word("out_word.word", out_word.word, exp_item.word);
                check_last("out_word.last", out_word.last, exp_item.last);
                in_packet = !exp_item.last;
            end else if (in_packet) begin
                abort_run("out_valid dropped in the middle of a packet");
            end
        end
    end

    // A writer that honours the flags never sees full
    always @(negedge wr_clk) begin
        if (!wr_reset) begin
            check_flag("full", full, 1'b0);
        end
    end

    initial begin
        rd_reset = 1'b1;
        repeat (3) @(posedge rd_clk);
        @(negedge rd_clk);
        rd_reset = 1'b0;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired with %0d words still expected", exp_q.size());
        $display("SOME TESTS FAILED");
        $fatal(1, "Run did not finish within %0d ns", TIMEOUT_NS);
    end

    initial begin
        int n;
        int held_words;
        in_word  = '0;
        in_valid = 1'b0;
        push     = 1'b0;
        wr_reset = 1'b1;
        repeat (3) @(posedge wr_clk);
        @(negedge wr_clk);
        wr_reset = 1'b0;
        wait (!rd_reset);
        @(negedge wr_clk);

        // Idle state after reset, any stray out_valid is caught by the comparator
        check_flag("full", full, 1'b0);
        check_flag("almost_full", almost_full, 1'b0);
        check_flag("has_packet_space", has_packet_space, 1'b1);
        repeat (QUIET_CYCLES) @(negedge wr_clk);

        for (int i = 0; i < PKT_WORDS; i++) begin
            write_word(1'b0); // One whole packet with all bytes enabled
        end
        wait_drained(0);

        for (int i = 0; i < 10; i++) begin
            write_word(1'b0);
        end
        flush();              // 40 byte packet
        wait_drained(0);
        repeat (QUIET_CYCLES) @(negedge wr_clk);

        // Back to back packets with random byte enables
        for (int i = 0; i < LOAD_PACKETS * PKT_WORDS; i++) begin
            write_word(1'b1);
        end
        wait_drained(0);
        // The last exchange must close and return its space before the host stops
        repeat (QUIET_CYCLES) @(negedge wr_clk);

        rd_run = 1'b0;        // Host stops reading, packets pile up
        n = 0;
        while (has_packet_space) begin
            if (n == CAP_WORDS) begin
                abort_run("has_packet_space never fell while the buffer filled");
            end
            write_word(1'b1);
            n++;
        end
        held_words = exp_q.size();
        rd_run = 1'b1;
        while (!has_packet_space) begin
            @(negedge wr_clk);
        end
        if (exp_q.size() > held_words - PKT_WORDS) begin
            abort_run("has_packet_space rose before a whole packet had drained");
        end
        wait_drained(model_held / WORD_BYTES); // Only the unfinished tail is left
        flush();
        wait_drained(0);
        repeat (QUIET_CYCLES) @(negedge wr_clk);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* verilog/async_word_fifo.sv */
/*
  Dual-clock word FIFO with Gray-coded pointers and first-word-fall-through read
  Writes are taken only while the FIFO has room, the caller must watch its own count
  Full is pessimistic by the read pointer sync delay
  Write to valid takes 3 to 4 rd_clk cycles depending on clock phase
*/
`timescale 1ns/1ps
`include "ft601_params.svh"

module async_word_fifo
    import ft601_pkg::*;
(
    input  logic        wr_clk,
    input  logic        wr_reset,
    input  logic        wr_en,
    input  ft601_word_t din,
    input  logic        rd_clk,
    input  logic        rd_reset,
    input  logic        rd_en,
    output ft601_word_t dout,
    output logic        valid
);

    localparam int DEPTH = `FT601_CAPACITY / `FT601_BYTES_PER_WORD;
    localparam int AW    = $clog2(DEPTH);
    localparam int PW    = AW + 1; // Extra bit tells full from empty
    localparam int SYNC  = `FT601_SYNC_STAGES;

    ft601_word_t   mem [DEPTH];

    logic [PW-1:0] wr_bin, wr_gray;
    logic [PW-1:0] rd_bin, rd_gray;
    logic [PW-1:0] rd_gray_sync [SYNC]; // Read pointer seen from wr_clk
    logic [PW-1:0] wr_gray_sync [SYNC]; // Write pointer seen from rd_clk
    logic          wr_full;
    logic          mem_empty;
    logic          load;

    function automatic logic [PW-1:0] to_gray(input logic [PW-1:0] b);
        return b ^ (b >> 1);
    endfunction

    // Full when the pointers differ only in the two top Gray bits
    assign wr_full = (wr_gray == {~rd_gray_sync[SYNC-1][PW-1:PW-2],
                                   rd_gray_sync[SYNC-1][PW-3:0]});

    always_ff @(posedge wr_clk) begin
        if (wr_reset) begin
            wr_bin  <= '0;
            wr_gray <= '0;
        end else if (wr_en && !wr_full) begin
            wr_bin  <= wr_bin + 1'b1;
            wr_gray <= to_gray(wr_bin + 1'b1); // Registered so only one bit moves per write
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_en && !wr_full) begin
            mem[wr_bin[AW-1:0]] <= din;
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_reset) begin
            for (int i = 0; i < SYNC; i++) begin
                rd_gray_sync[i] <= '0;
            end
        end else begin
            rd_gray_sync[0] <= rd_gray;
            for (int i = 1; i < SYNC; i++) begin
                rd_gray_sync[i] <= rd_gray_sync[i-1];
            end
        end
    end

    always_ff @(posedge rd_clk) begin
        if (rd_reset) begin
            for (int i = 0; i < SYNC; i++) begin
                wr_gray_sync[i] <= '0;
            end
        end else begin
            wr_gray_sync[0] <= wr_gray;
            for (int i = 1; i < SYNC; i++) begin
                wr_gray_sync[i] <= wr_gray_sync[i-1];
            end
        end
    end

    // The output register is refilled whenever it is empty or being consumed
    assign mem_empty = (rd_gray == wr_gray_sync[SYNC-1]);
    assign load      = !mem_empty && (!valid || rd_en);

    always_ff @(posedge rd_clk) begin
        if (rd_reset) begin
            rd_bin  <= '0;
            rd_gray <= '0;
            valid   <= 1'b0;
        end else if (load) begin
            rd_bin  <= rd_bin + 1'b1;
            rd_gray <= to_gray(rd_bin + 1'b1);
            valid   <= 1'b1;
        end else if (rd_en) begin
            valid   <= 1'b0; // Last held word consumed with nothing behind it
        end
    end

    always_ff @(posedge rd_clk) begin
        if (load) begin
            dout <= mem[rd_bin[AW-1:0]];
        end
    end

    // The buffer's byte count must keep writes away from a full FIFO
    a_no_overflow: assert property (@(posedge wr_clk) disable iff (wr_reset)
        wr_en |-> !wr_full);

    a_no_underflow: assert property (@(posedge rd_clk) disable iff (rd_reset)
        rd_en |-> valid);

endmodule

/* verilog/ft601_burst_reader.sv */
/*
  Burst reader standing in for the FT601 bus engine
  Takes every valid FIFO word while a transfer is open, one word per clock
  The host side is taken as always ready, there is no back-pressure on the output
  Output appears one rd_clk cycle after the word is taken
*/
`timescale 1ns/1ps

module ft601_burst_reader
    import ft601_pkg::*;
(
    input  logic        rd_clk,
    input  logic        rd_reset,
    input  logic        xfer_req,
    input  logic        xfer_almost_done,
    input  ft601_word_t rd_word,
    input  logic        rd_valid,
    output logic        rd_en,
    output ft601_out_t  out_word,
    output logic        out_valid
);

    logic in_burst_q; // From the request until the word flagged last has gone out

    // Whole packet is already buffered, so words stream on back to back clocks
    assign rd_en = xfer_req && rd_valid;

    always_ff @(posedge rd_clk) begin
        if (rd_reset) begin
            out_valid  <= 1'b0;
            in_burst_q <= 1'b0;
        end else begin
            out_valid <= rd_en;
            if (out_valid && out_word.last) begin
                in_burst_q <= 1'b0; // Burst closes with its last word
            end else if (xfer_req) begin
                in_burst_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge rd_clk) begin
        if (rd_en) begin
            out_word.word <= rd_word;
            out_word.last <= xfer_almost_done; // Word that completes the byte count
        end
    end

    // The request gating must close the burst right after its last word
    a_valid_in_burst: assert property (@(posedge rd_clk) disable iff (rd_reset)
        out_valid |-> in_burst_q);

endmodule

/* verilog/ft601_mcfifo_wr_buf.sv */
/*
  Packetizing write buffer between application logic and the FT601 bus engine
  A transfer opens when a full packet is held or after push, one transfer at a time
  The writer must not strobe while full is high, writes then are dropped
  Space is returned only after the read side has finished the whole transfer
  MAX_PACKET_SIZE is 1024, 2048 or 4096 bytes and is fixed at build time
*/
`timescale 1ns/1ps
`include "ft601_params.svh"

module ft601_mcfifo_wr_buf
    import ft601_pkg::*;
#(
    parameter int MAX_PACKET_SIZE = `FT601_MAX_PACKET
) (
    input  logic        wr_clk,
    input  logic        wr_reset,
    input  ft601_word_t in_word,
    input  logic        in_valid,
    input  logic        push,
    output logic        full,
    output logic        almost_full,
    output logic        has_packet_space, // A whole packet can still be written
    input  logic        rd_clk,
    input  logic        rd_reset,
    output ft601_word_t rd_word,
    output logic        rd_valid,
    input  logic        rd_en,
    output logic        xfer_req,
    output logic        xfer_almost_done
);

    localparam int SW = `FT601_SIZE_W;
    localparam logic [SW-1:0] CAP_BYTES  = SW'(`FT601_CAPACITY);
    localparam logic [SW-1:0] PKT_BYTES  = SW'(MAX_PACKET_SIZE);
    localparam logic [SW-1:0] WORD_BYTES = SW'(`FT601_BYTES_PER_WORD);

    if (MAX_PACKET_SIZE != 1024 && MAX_PACKET_SIZE != 2048 && MAX_PACKET_SIZE != 4096)
    begin : g_bad_packet_size
        $error("MAX_PACKET_SIZE must be 1024, 2048 or 4096");
    end

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_REQ,
        ST_REQ_ACK,
        ST_WAIT_DONE,
        ST_ACK_DONE
    } state_t;

    state_t          state;
    logic [SW-1:0]   byte_count;   // Bytes written and not yet released
    logic [SW-1:0]   xfer_size;
    logic            src_send;
    logic            src_rcv;
    logic            push_pending; // Flush asked for while a transfer was busy
    logic            wr_accept;
    logic            has_full_packet;
    logic            start;
    logic [SW-1:0]   rd_size;
    logic            rd_req_int;   // Stays up until the handshake completes
    logic [SW-1:0]   rd_count;
    logic            rd_done;

    assign wr_accept        = in_valid && !full;
    assign full             = (byte_count >= CAP_BYTES);
    assign almost_full      = (byte_count >= CAP_BYTES - WORD_BYTES);
    assign has_packet_space = (byte_count <= CAP_BYTES - PKT_BYTES);
    assign has_full_packet  = (byte_count >= PKT_BYTES);
    // An empty flush is dropped, a zero size would never complete
    assign start = has_full_packet || ((push || push_pending) && byte_count != '0);

    always_ff @(posedge wr_clk) begin
        if (wr_reset) begin
            state        <= ST_IDLE;
            src_send     <= 1'b0;
            xfer_size    <= '0;
            push_pending <= 1'b0;
        end else begin
            if (state == ST_IDLE) begin
                push_pending <= 1'b0; // Either taken now or nothing to flush
            end else if (push) begin
                push_pending <= 1'b1;
            end
            case (state)
                ST_IDLE: if (start) state <= ST_REQ;
                ST_REQ: begin
                    xfer_size <= has_full_packet ? PKT_BYTES : byte_count;
                    src_send  <= 1'b1;
                    state     <= ST_REQ_ACK;
                end
                ST_REQ_ACK: if (src_rcv) begin
                    src_send <= 1'b0; // Read side has finished the burst
                    state    <= ST_WAIT_DONE;
                end
                ST_WAIT_DONE: if (!src_rcv) state <= ST_ACK_DONE;
                ST_ACK_DONE: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Space comes back only once the four-phase exchange has closed
    always_ff @(posedge wr_clk) begin
        if (wr_reset) begin
            byte_count <= '0;
        end else begin
            byte_count <= byte_count
                        + (wr_accept ? WORD_BYTES : '0)
                        - ((state == ST_ACK_DONE) ? xfer_size : '0);
        end
    end

    async_word_fifo u_fifo (
        .wr_clk   (wr_clk),
        .wr_reset (wr_reset),
        .wr_en    (wr_accept),
        .din      (in_word),
        .rd_clk   (rd_clk),
        .rd_reset (rd_reset),
        .rd_en    (rd_en),
        .dout     (rd_word),
        .valid    (rd_valid)
    );

    xfer_size_handshake u_hsk (
        .src_clk    (wr_clk),
        .src_reset  (wr_reset),
        .src_send   (src_send),
        .src_size   (xfer_size),
        .src_rcv    (src_rcv),
        .dest_clk   (rd_clk),
        .dest_reset (rd_reset),
        .dest_ack   (rd_done),
        .dest_size  (rd_size),
        .dest_req   (rd_req_int)
    );

    // Counter restarts from zero for every request
    always_ff @(posedge rd_clk) begin
        if (rd_reset || !rd_req_int) begin
            rd_count <= '0;
        end else if (rd_en) begin
            rd_count <= rd_count + WORD_BYTES;
        end
    end

    assign rd_done          = rd_req_int && (rd_count == rd_size);
    assign xfer_req         = rd_req_int && !rd_done; // Drops at once so no extra word is read
    assign xfer_almost_done = rd_req_int && (rd_count == rd_size - WORD_BYTES);

    a_count_in_range: assert property (@(posedge wr_clk) disable iff (wr_reset)
        byte_count <= CAP_BYTES);

endmodule

/* verilog/ft601_params.svh */
/*
  Build constants for the FT601 write path
  Capacity must hold at least two packets of the largest size in use
  Byte counts are multiples of the word size, so partial byte enables still cost a full word
  Packet size is fixed at build time and cannot change while transfers run
*/
`ifndef FT601_PARAMS_SVH
`define FT601_PARAMS_SVH

// Buffer size in bytes, two 4096 byte packets
`define FT601_CAPACITY 8192

// Default packet size, 1024 for four channels, 2048 for two, 4096 for one
`define FT601_MAX_PACKET 1024

// Bytes carried by one bus word
`define FT601_BYTES_PER_WORD 4

// Width of byte counters and transfer sizes
`define FT601_SIZE_W 16

// Flip-flops in each clock domain crossing chain
`define FT601_SYNC_STAGES 2

`endif

/* verilog/ft601_pkg.sv */
/*
  Payload types shared by the FT601 write path
  A word keeps its byte enables next to the data, as on the FT601 bus
  The output type adds the end of packet flag seen by the host side
*/
package ft601_pkg;

    // One bus word as written by the application
    typedef struct packed {
        logic [3:0]  be;   // Byte enable per data byte, bit 0 for data[7:0]
        logic [31:0] data;
    } ft601_word_t;

    // Word leaving the burst reader
    typedef struct packed {
        ft601_word_t word;
        logic        last; // High on the final word of a packet
    } ft601_out_t;

endpackage

/* verilog/ft601_wr_path_top.sv */
/*
  FT601 write path, packet buffer followed by the burst reader
  Write port and status live in wr_clk, packet output in rd_clk
  The writer must honour full, the output has no back-pressure
*/
`timescale 1ns/1ps
`include "ft601_params.svh"

module ft601_wr_path_top
    import ft601_pkg::*;
#(
    parameter int MAX_PACKET_SIZE = `FT601_MAX_PACKET
) (
    input  logic        wr_clk,
    input  logic        wr_reset,
    input  ft601_word_t in_word,
    input  logic        in_valid,
    input  logic        push,
    output logic        full,
    output logic        almost_full,
    output logic        has_packet_space,
    input  logic        rd_clk,
    input  logic        rd_reset,
    output ft601_out_t  out_word,
    output logic        out_valid
);

    ft601_word_t rd_word;
    logic        rd_valid;
    logic        rd_en;
    logic        xfer_req;
    logic        xfer_almost_done;

    ft601_mcfifo_wr_buf #(
        .MAX_PACKET_SIZE (MAX_PACKET_SIZE)
    ) u_wr_buf (
        .wr_clk           (wr_clk),
        .wr_reset         (wr_reset),
        .in_word          (in_word),
        .in_valid         (in_valid),
        .push             (push),
        .full             (full),
        .almost_full      (almost_full),
        .has_packet_space (has_packet_space),
        .rd_clk           (rd_clk),
        .rd_reset         (rd_reset),
        .rd_word          (rd_word),
        .rd_valid         (rd_valid),
        .rd_en            (rd_en),
        .xfer_req         (xfer_req),
        .xfer_almost_done (xfer_almost_done)
    );

    ft601_burst_reader u_reader (
        .rd_clk           (rd_clk),
        .rd_reset         (rd_reset),
        .xfer_req         (xfer_req),
        .xfer_almost_done (xfer_almost_done),
        .rd_word          (rd_word),
        .rd_valid         (rd_valid),
        .rd_en            (rd_en),
        .out_word         (out_word),
        .out_valid        (out_valid)
    );

endmodule

/* verilog/xfer_size_handshake.sv */
/*
  Four-phase request/acknowledge crossing for a transfer size
  src_send must stay high until src_rcv rises, then stay low until src_rcv falls
  dest_ack must stay high until dest_req falls
  One exchange costs several clocks on each side, so it suits rare control events only
*/
`timescale 1ns/1ps
`include "ft601_params.svh"

module xfer_size_handshake (
    input  logic                     src_clk,
    input  logic                     src_reset,
    input  logic                     src_send,
    input  logic [`FT601_SIZE_W-1:0] src_size,
    output logic                     src_rcv,
    input  logic                     dest_clk,
    input  logic                     dest_reset,
    input  logic                     dest_ack,
    output logic [`FT601_SIZE_W-1:0] dest_size,
    output logic                     dest_req
);

    localparam int SYNC = `FT601_SYNC_STAGES;

    logic                     src_req_q;
    logic [`FT601_SIZE_W-1:0] src_size_q; // Held still for the whole exchange
    logic [SYNC-1:0]          req_sync;
    logic [SYNC-1:0]          ack_sync;

    always_ff @(posedge src_clk) begin
        if (src_reset) begin
            src_req_q <= 1'b0;
            ack_sync  <= '0;
        end else begin
            src_req_q <= src_send;
            ack_sync  <= {ack_sync[SYNC-2:0], dest_ack};
        end
    end

    always_ff @(posedge src_clk) begin
        if (src_send && !src_req_q) begin
            src_size_q <= src_size; // Captured on the rising edge of the request
        end
    end

    assign src_rcv = ack_sync[SYNC-1];

    always_ff @(posedge dest_clk) begin
        if (dest_reset) begin
            req_sync <= '0;
            dest_req <= 1'b0;
        end else begin
            req_sync <= {req_sync[SYNC-2:0], src_req_q};
            dest_req <= req_sync[SYNC-1];
        end
    end

    // Size register is stable long before the request arrives here
    always_ff @(posedge dest_clk) begin
        if (req_sync[SYNC-1] && !dest_req) begin
            dest_size <= src_size_q;
        end
    end

    a_size_stable: assert property (@(posedge src_clk) disable iff (src_reset)
        src_send && src_req_q |-> src_size == src_size_q);

endmodule
